// File: common/hazardPkg.sv
package hazardPkg;

    // Register file geometry
    localparam int regAddrWidth = 4;            // 16 architectural registers

    // Register number as carried in the stage tags
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // EX operand source select
    typedef logic [1:0] forwardSel_t;

    // Operand comes straight from the register file read in ID
    localparam forwardSel_t fwdNone  = 2'b00;
    // Operand comes from the MEM/WB register (ALU result or load data)
    localparam forwardSel_t fwdMemWb = 2'b01;
    // Operand comes from the EX/MEM register, the newest producer
    localparam forwardSel_t fwdExMem = 2'b10;
    // 2'b11 is never produced

    // Hard-wired zero register
    // Writes to it are discarded, so it is never a forwarding or stall source
    localparam regAddr_t zeroReg = '0;

endpackage

// File: hazard/forwardingUnit.sv
`timescale 1ns/1ps

module forwardingUnit (
    // Consumer in EX
    input  hazardPkg::regAddr_t    idExRs,          // Operand A source
    input  hazardPkg::regAddr_t    idExRt,          // Operand B source, also store data
    // Producer one instruction ahead
    input  hazardPkg::regAddr_t    exMemRd,
    input  logic                   exMemRegWrite,   // Already gated with stage valid
    // Producer two instructions ahead
    input  hazardPkg::regAddr_t    memWbRd,
    input  logic                   memWbRegWrite,   // Already gated with stage valid
    output hazardPkg::forwardSel_t forwardA,
    output hazardPkg::forwardSel_t forwardB,
    output logic                   memForward       // MEM-to-MEM, one cycle early
);
    import hazardPkg::*;

    logic exMemWrites;                              // EX/MEM result is a real register
    logic memWbWrites;                              // MEM/WB result is a real register

    // Picks the source of one EX operand
    // EX/MEM is checked first since it holds the younger result
    function automatic forwardSel_t selectSource(input regAddr_t src);
        forwardSel_t sel;
        if (exMemWrites && (exMemRd == src)) begin
            sel = fwdExMem;                         // EX-to-EX
        end else if (memWbWrites && (memWbRd == src)) begin
            sel = fwdMemWb;                         // MEM-to-EX
        end else begin
            sel = fwdNone;                          // Register file value is current
        end
        return sel;
    endfunction

    assign exMemWrites = exMemRegWrite && (exMemRd != zeroReg);
    assign memWbWrites = memWbRegWrite && (memWbRd != zeroReg);

    // Same rule for both operands, Rs feeds A and Rt feeds B
    assign forwardA = selectSource(idExRs);
    assign forwardB = selectSource(idExRt);

    // MEM-to-MEM store data forward
    // Wanted when the store sits in EX/MEM and its data producer in MEM/WB
    // Evaluated one stage earlier on the same pair, the tracker delays it
    // by one edge so it lines up with the store reaching MEM
    assign memForward = exMemWrites && (exMemRd == idExRt);

endmodule

// File: hazard/loadUseDetector.sv
`timescale 1ns/1ps

module loadUseDetector (
    // Load candidate in EX
    input  logic                idExMemRead,    // Gated with stage valid
    input  hazardPkg::regAddr_t idExRd,
    // Possible consumer in ID
    input  hazardPkg::regAddr_t ifIdRs,
    input  hazardPkg::regAddr_t ifIdRt,
    input  logic                ifIdMemWrite,   // Gated with stage valid
    output logic                loadStall
);
    import hazardPkg::*;

    logic loadInEx;     // Real load to a writable register
    logic rsDepends;    // ID needs load data as operand A
    logic rtDepends;    // ID needs load data as operand B

    // Load data is only available at the end of MEM
    // A consumer right behind it cannot get it in time for EX
    assign loadInEx  = idExMemRead && (idExRd != zeroReg);
    assign rsDepends = (idExRd == ifIdRs);

    // Store data through Rt is read in MEM, not EX
    // MEM-to-MEM forwarding covers that case without a stall
    assign rtDepends = (idExRd == ifIdRt) && !ifIdMemWrite;

    // One bubble is enough, afterwards the load sits in MEM/WB
    assign loadStall = loadInEx && (rsDepends || rtDepends);

endmodule

// File: hdl/stageTracker.sv
`timescale 1ns/1ps

module stageTracker (
    input  logic                clk,
    input  logic                reset,
    // Decoded instruction from ID decode
    input  logic                instValid,
    input  hazardPkg::regAddr_t instRs,
    input  hazardPkg::regAddr_t instRt,
    input  hazardPkg::regAddr_t instRd,
    input  logic                instRegWrite,
    input  logic                instMemRead,
    input  logic                instMemWrite,
    // Detector results
    input  logic                loadStall,
    input  logic                memForward,
    // IF/ID tags
    output hazardPkg::regAddr_t ifIdRs,
    output hazardPkg::regAddr_t ifIdRt,
    output logic                ifIdMemWrite,
    // ID/EX tags
    output hazardPkg::regAddr_t idExRs,
    output hazardPkg::regAddr_t idExRt,
    output hazardPkg::regAddr_t idExRd,
    output logic                idExRegWrite,
    output logic                idExMemRead,
    // EX/MEM tags
    output hazardPkg::regAddr_t exMemRd,
    output logic                exMemRegWrite,
    // MEM/WB tags
    output hazardPkg::regAddr_t memWbRd,
    output logic                memWbRegWrite,
    output logic                forwardC        // Store data from MEM/WB, store now in MEM
);
    import hazardPkg::*;

    // Stage valid bits
    logic ifIdValid;
    logic idExValid;
    logic exMemValid;
    logic memWbValid;

    // Raw stage payload, meaningful only while the stage is valid
    regAddr_t ifIdRsQ;
    regAddr_t ifIdRtQ;
    regAddr_t ifIdRdQ;
    logic     ifIdRegWriteQ;
    logic     ifIdMemReadQ;
    logic     ifIdMemWriteQ;
    regAddr_t idExRsQ;
    regAddr_t idExRtQ;
    regAddr_t idExRdQ;
    logic     idExRegWriteQ;
    logic     idExMemReadQ;
    regAddr_t exMemRdQ;
    logic     exMemRegWriteQ;
    regAddr_t memWbRdQ;
    logic     memWbRegWriteQ;

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            ifIdValid  <= 1'b0;
            idExValid  <= 1'b0;
            exMemValid <= 1'b0;
            memWbValid <= 1'b0;
            forwardC   <= 1'b0;
        end else begin
            if (!loadStall) begin
                ifIdValid <= instValid;             // Accept or take an empty slot
            end
            idExValid  <= ifIdValid && !loadStall;  // Bubble on stall
            exMemValid <= idExValid;                // Back half never stops
            memWbValid <= exMemValid;
            forwardC   <= memForward;               // Follows the store into MEM
        end
    end

    // Payload shift, held in IF/ID while stalled
    always_ff @(posedge clk) begin
        if (!loadStall) begin
            ifIdRsQ       <= instRs;
            ifIdRtQ       <= instRt;
            ifIdRdQ       <= instRd;
            ifIdRegWriteQ <= instRegWrite;
            ifIdMemReadQ  <= instMemRead;
            ifIdMemWriteQ <= instMemWrite;
        end
        idExRsQ        <= ifIdRsQ;                  // Don't care on a bubble
        idExRtQ        <= ifIdRtQ;
        idExRdQ        <= ifIdRdQ;
        idExRegWriteQ  <= ifIdRegWriteQ;
        idExMemReadQ   <= ifIdMemReadQ;
        exMemRdQ       <= idExRdQ;
        exMemRegWriteQ <= idExRegWriteQ;
        memWbRdQ       <= exMemRdQ;
        memWbRegWriteQ <= exMemRegWriteQ;
    end

    // Empty stages show register 0 and no enables
    // so stale fields never match in the detectors
    assign ifIdRs        = ifIdValid ? ifIdRsQ : zeroReg;
    assign ifIdRt        = ifIdValid ? ifIdRtQ : zeroReg;
    assign ifIdMemWrite  = ifIdValid && ifIdMemWriteQ;
    assign idExRs        = idExValid ? idExRsQ : zeroReg;
    assign idExRt        = idExValid ? idExRtQ : zeroReg;
    assign idExRd        = idExValid ? idExRdQ : zeroReg;
    assign idExRegWrite  = idExValid && idExRegWriteQ;
    assign idExMemRead   = idExValid && idExMemReadQ;
    assign exMemRd       = exMemValid ? exMemRdQ : zeroReg;
    assign exMemRegWrite = exMemValid && exMemRegWriteQ;
    assign memWbRd       = memWbValid ? memWbRdQ : zeroReg;
    assign memWbRegWrite = memWbValid && memWbRegWriteQ;

endmodule

// File: hdl/pipelineHazardCtrl.sv
`timescale 1ns/1ps

module pipelineHazardCtrl (
    input  logic                   clk,
    input  logic                   reset,
    // Decoder side, held by the source while stall is high
    input  logic                   instValid,
    input  hazardPkg::regAddr_t    instRs,
    input  hazardPkg::regAddr_t    instRt,
    input  hazardPkg::regAddr_t    instRd,
    input  logic                   instRegWrite,
    input  logic                   instMemRead,
    input  logic                   instMemWrite,
    // Datapath controls
    output hazardPkg::forwardSel_t forwardA,    // EX operand A mux
    output hazardPkg::forwardSel_t forwardB,    // EX operand B mux
    output logic                   forwardC,    // MEM store data mux
    output logic                   stall        // Hold front end, bubble into ID/EX
);
    import hazardPkg::*;

    // Stage tags from the tracker
    regAddr_t ifIdRs;
    regAddr_t ifIdRt;
    logic     ifIdMemWrite;
    regAddr_t idExRs;
    regAddr_t idExRt;
    regAddr_t idExRd;
    logic     idExRegWrite;
    logic     idExMemRead;
    regAddr_t exMemRd;
    logic     exMemRegWrite;
    regAddr_t memWbRd;
    logic     memWbRegWrite;
    logic     memForward;       // Early MEM-to-MEM decision

    // Stage registers, stall and bubble handling
    stageTracker tracker_i (
        .clk           (clk),
        .reset         (reset),
        .instValid     (instValid),
        .instRs        (instRs),
        .instRt        (instRt),
        .instRd        (instRd),
        .instRegWrite  (instRegWrite),
        .instMemRead   (instMemRead),
        .instMemWrite  (instMemWrite),
        .loadStall     (stall),
        .memForward    (memForward),
        .ifIdRs        (ifIdRs),
        .ifIdRt        (ifIdRt),
        .ifIdMemWrite  (ifIdMemWrite),
        .idExRs        (idExRs),
        .idExRt        (idExRt),
        .idExRd        (idExRd),
        .idExRegWrite  (idExRegWrite),
        .idExMemRead   (idExMemRead),
        .exMemRd       (exMemRd),
        .exMemRegWrite (exMemRegWrite),
        .memWbRd       (memWbRd),
        .memWbRegWrite (memWbRegWrite),
        .forwardC      (forwardC)
    );

    // Operand bypass for EX and store data bypass
    forwardingUnit forward_i (
        .idExRs        (idExRs),
        .idExRt        (idExRt),
        .exMemRd       (exMemRd),
        .exMemRegWrite (exMemRegWrite),
        .memWbRd       (memWbRd),
        .memWbRegWrite (memWbRegWrite),
        .forwardA      (forwardA),
        .forwardB      (forwardB),
        .memForward    (memForward)
    );

    // Load followed directly by a consumer
    loadUseDetector loadUse_i (
        .idExMemRead  (idExMemRead),
        .idExRd       (idExRd),
        .ifIdRs       (ifIdRs),
        .ifIdRt       (ifIdRt),
        .ifIdMemWrite (ifIdMemWrite),
        .loadStall    (stall)
    );

endmodule

// File: testbench/pipelineHazardCtrl_chk.sv
`timescale 1ns/1ps

module pipelineHazardCtrl_chk (
    input logic                   clk,
    input logic                   reset,
    input hazardPkg::forwardSel_t forwardA,
    input hazardPkg::forwardSel_t forwardB,
    input logic                   forwardC,
    input logic                   stall
);
    import hazardPkg::*;

    // Unused select encoding, no mux input behind it
    selAEncoding: assert property (
        @(posedge clk) disable iff (reset) forwardA != 2'b11
    ) else $error("forwardA took the unused encoding 2'b11");

    selBEncoding: assert property (
        @(posedge clk) disable iff (reset) forwardB != 2'b11
    ) else $error("forwardB took the unused encoding 2'b11");

    // All stages empty right after a reset edge
    quietAfterReset: assert property (
        @(posedge clk) reset |=> (forwardA == fwdNone) && (forwardB == fwdNone) &&
                                 !forwardC && !stall
    ) else $error("control output active in the cycle after reset");

    // Bubble behind the load clears the hazard
    singleCycleStall: assert property (
        @(posedge clk) disable iff (reset) stall |=> !stall
    ) else $error("stall held for two consecutive cycles");

endmodule

bind pipelineHazardCtrl pipelineHazardCtrl_chk chk_i (
    .clk      (clk),
    .reset    (reset),
    .forwardA (forwardA),
    .forwardB (forwardB),
    .forwardC (forwardC),
    .stall    (stall)
);

// File: testbench/pipelineHazardCtrlTb.sv
`timescale 1ns/1ps

module pipelineHazardCtrlTb;
    import hazardPkg::*;

    localparam int    resetCycles   = 3;
    localparam int    timeoutCycles = 20;      // Settling limit after reset release
    localparam int    maxLines      = 200;     // Upper bound on stim file length
    localparam string stimPath      = "testbench/hazardStim.txt";

    // DUT ports
    logic        clk;
    logic        reset;
    logic        instValid;
    regAddr_t    instRs;
    regAddr_t    instRt;
    regAddr_t    instRd;
    logic        instRegWrite;
    logic        instMemRead;
    logic        instMemWrite;
    forwardSel_t forwardA;
    forwardSel_t forwardB;
    logic        forwardC;
    logic        stall;

    // One stim line holding inputs then expected outputs
    logic        stimReset;
    logic        stimValid;
    regAddr_t    stimRs;
    regAddr_t    stimRt;
    regAddr_t    stimRd;
    logic        stimRegWrite;
    logic        stimMemRead;
    logic        stimMemWrite;
    forwardSel_t expA;
    forwardSel_t expB;
    logic        expC;
    logic        expStall;

    int fd;                                    // Stim file handle

    pipelineHazardCtrl dut_i (
        .clk          (clk),
        .reset        (reset),
        .instValid    (instValid),
        .instRs       (instRs),
        .instRt       (instRt),
        .instRd       (instRd),
        .instRegWrite (instRegWrite),
        .instMemRead  (instMemRead),
        .instMemWrite (instMemWrite),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .forwardC     (forwardC),
        .stall        (stall)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                     // 100 ns period

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at first failure");
    endtask

    // Compare for the EX operand selects
    task automatic checkSel(input string name, input forwardSel_t expected,
                            input forwardSel_t actual);
        if (actual !== expected) begin
            failRun($sformatf("error at %0d ns: %s expected %0d actual %0d",
                              $time, name, expected, actual));
        end
    endtask

    // Compare for single bit controls
    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("error at %0d ns: %s expected %b actual %b",
                              $time, name, expected, actual));
        end
    endtask

    function automatic logic outputsIdle();
        return (forwardA === fwdNone) && (forwardB === fwdNone) &&
               (forwardC === 1'b0) && (stall === 1'b0);
    endfunction

    task automatic driveIdle();
        instValid    = 1'b0;                   // Empty slot
        instRs       = zeroReg;
        instRt       = zeroReg;
        instRd       = zeroReg;
        instRegWrite = 1'b0;
        instMemRead  = 1'b0;
        instMemWrite = 1'b0;
    endtask

    task automatic applyReset();
        int cycle;
        int waited;
        reset = 1'b1;
        driveIdle();
        for (cycle = 0; cycle < resetCycles; cycle++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset  = 1'b0;
        waited = 0;
        // Empty pipeline must show no activity
        while (!outputsIdle()) begin
            if (waited >= timeoutCycles) begin
                failRun("outputs stayed active after reset was released");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic applyLine();
        reset        = stimReset;
        instValid    = stimValid;
        instRs       = stimRs;
        instRt       = stimRt;
        instRd       = stimRd;
        instRegWrite = stimRegWrite;
        instMemRead  = stimMemRead;
        instMemWrite = stimMemWrite;
    endtask

    task automatic compareLine();
        checkSel("forwardA", expA, forwardA);
        checkSel("forwardB", expB, forwardB);
        checkBit("forwardC", expC, forwardC);
        checkBit("stall", expStall, stall);
    endtask

    // One data line per cycle checked at the following falling edge
    task automatic runStim();
        string line;
        int    code;
        int    fields;
        int    linesRead;
        int    applied;
        linesRead = 0;
        applied   = 0;
        while (!$feof(fd)) begin
            if (linesRead >= maxLines) begin
                failRun("stimulus file did not end within the line limit");
            end else begin
                code = $fgets(line, fd);
                linesRead++;
                fields = 0;
                if (code > 0 && line.substr(0, 0) != "#") begin    // Skip column notes
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                     stimReset, stimValid, stimRs, stimRt, stimRd,
                                     stimRegWrite, stimMemRead, stimMemWrite,
                                     expA, expB, expC, expStall);
                end
                if (fields == 12) begin
                    applyLine();
                    @(negedge clk);
                    compareLine();
                    applied++;
                end else if (fields > 0) begin
                    failRun($sformatf("stimulus line %0d has missing fields", linesRead));
                end
            end
        end
        if (applied == 0) begin
            failRun("stimulus file holds no test lines");
        end
    endtask

    initial begin
        reset = 1'b1;
        driveIdle();
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            failRun("could not open the stimulus file testbench/hazardStim.txt");
        end
        applyReset();
        runStim();
        $fclose(fd);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: testbench/hazardStim.txt
# rst valid rs rt rd regWrite memRead memWrite  expForwardA expForwardB expForwardC expStall
# hex fields, expected values apply at the falling edge after the line is driven
# ALU chain, EX/MEM and MEM/WB forwarding, EX/MEM priority
0 1 2 3 1 1 0 0  0 0 0 0
0 1 1 5 4 1 0 0  0 0 0 0
0 1 7 4 6 1 0 0  2 0 0 0
0 1 4 6 6 1 0 0  0 2 0 0
0 1 6 0 a 1 0 0  1 2 1 0
# Producers to r0 or without regWrite
0 1 2 3 0 1 0 0  2 0 1 0
0 1 0 0 7 0 0 0  0 0 0 0
0 1 7 0 b 1 0 0  0 0 0 0
# Load then use through rs, held instruction repeated
0 1 2 0 5 1 1 0  0 0 0 0
0 1 5 1 9 1 0 0  0 0 0 1
0 1 9 0 c 1 0 0  0 0 0 0
0 1 9 0 c 1 0 0  1 0 0 0
# Load then store of the loaded register
0 1 4 0 3 1 1 0  2 0 0 0
0 1 6 3 0 0 0 1  0 0 0 0
0 0 0 0 0 0 0 0  0 2 0 0
0 0 0 0 0 0 0 0  0 0 1 0
0 0 0 0 0 0 0 0  0 0 0 0
# Load then use through rt
0 1 1 0 8 1 1 0  0 0 0 0
0 1 1 8 2 1 0 0  0 0 0 1
0 1 2 2 3 1 0 0  0 0 0 0
0 1 2 2 3 1 0 0  0 1 0 0
# Reset during a stall
0 1 5 0 2 1 1 0  2 2 0 0
0 1 2 0 4 1 0 0  0 0 1 1
1 1 4 4 5 1 0 0  0 0 0 0
0 1 4 4 5 1 0 0  0 0 0 0
0 1 5 4 6 1 0 0  0 0 0 0
0 0 0 0 0 0 0 0  2 0 0 0
0 0 0 0 0 0 0 0  0 0 0 0
0 0 0 0 0 0 0 0  0 0 0 0

// File: pipelineHazardCtrl.f
common/hazardPkg.sv
hazard/forwardingUnit.sv
hazard/loadUseDetector.sv
hdl/stageTracker.sv
hdl/pipelineHazardCtrl.sv
testbench/pipelineHazardCtrl_chk.sv
testbench/pipelineHazardCtrlTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := pipelineHazardCtrlTb
FILELIST  := pipelineHazardCtrl.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
